// File: Bender.yml
package:
  name: decoder_ctrl

sources:
  - files:
      - verilog/ctrl_msg_pkg.sv
      - verilog/child_node.sv
      - verilog/fpga_link_router.sv
      - verilog/root_controller.sv
      - verilog/decoder_ctrl_top.sv
  - target: test
    files:
      - verification/decoder_ctrl_tb.sv

// File: decoder_ctrl_top.f
verilog/ctrl_msg_pkg.sv
verilog/child_node.sv
verilog/fpga_link_router.sv
verilog/root_controller.sv
verilog/decoder_ctrl_top.sv
verification/decoder_ctrl_tb.sv

// File: verification/decoder_ctrl_tb.sv
module decoder_ctrl_tb import ctrl_msg_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_children = 4;
    localparam int wait_limit   = 2000;

    logic        clk;
    logic        reset;
    msg_word_u   cpu_in_data;
    logic        cpu_in_valid;
    logic        cpu_in_ready;
    msg_word_u   cpu_out_data;
    logic        cpu_out_valid;
    logic        cpu_out_ready = 1'b0;

    // expectations kept by the stimulus
    logic        out_allowed;
    logic        report_mode;
    logic        stall_on;
    logic [7:0]  exp_boundary [num_children];

    // what the CPU has taken since its last accepted command
    logic [num_children-1:0] seen_ids;
    int          words_out;

    logic [7:0]  out_header;
    logic [7:0]  out_source;
    logic        src_in_range;

    assign out_header   = cpu_out_data.res.header;
    assign out_source   = cpu_out_data.res.source_id;
    assign src_in_range = (out_source >= 8'd1) && (out_source <= 8'(num_children));

    decoder_ctrl_top #(
        .num_children(num_children)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .cpu_in_data  (cpu_in_data),
        .cpu_in_valid (cpu_in_valid),
        .cpu_in_ready (cpu_in_ready),
        .cpu_out_data (cpu_out_data),
        .cpu_out_valid(cpu_out_valid),
        .cpu_out_ready(cpu_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic stop_on_timeout(input logic met, input string what);
        if (!met) begin
            $display("tests failed");
            $fatal(1, "timed out: %s", what);
        end
    endtask

    function automatic msg_word_u build_command(input logic [7:0] dest,
                                                input logic [7:0] header,
                                                input logic [7:0] boundary,
                                                input logic [7:0] cycles,
                                                input logic       wait_flag,
                                                input logic       report_flag);
        msg_word_u word;
        word                   = '0;
        word.cmd.dest          = dest;
        word.cmd.header        = header;
        word.cmd.boundary      = boundary;
        word.cmd.decode_cycles = cycles;
        word.cmd.wait_result   = wait_flag;
        word.cmd.report_all    = report_flag;
        return word;
    endfunction

    // hold the word until the DUT takes it
    task automatic send_word(input msg_word_u word);
        int n;
        n = 0;
        @(posedge clk);
        cpu_in_data  <= word;
        cpu_in_valid <= 1'b1;
        @(negedge clk);
        while (!cpu_in_ready && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        stop_on_timeout(cpu_in_ready, "the CPU word was never accepted");
        @(posedge clk);
        cpu_in_valid <= 1'b0;
    endtask

    task automatic await_report();
        int n;
        n = 0;
        @(negedge clk);
        while (!(cpu_out_valid && cpu_out_ready && out_header == header_latency) &&
               n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        stop_on_timeout(cpu_out_valid && cpu_out_ready && out_header == header_latency,
                        "the latency report never reached the CPU");
        @(posedge clk);
        out_allowed <= 1'b0;
    endtask

    task automatic run_decode(input logic report_flag);
        logic [7:0] cycles;
        cycles = 8'($urandom % 24);
        send_word(build_command(dest_root, header_decode_block, 8'h00, cycles, 1'b1,
                                report_flag));
        out_allowed <= 1'b1;
        report_mode <= report_flag;
        await_report();
    endtask

    // random back-pressure on the CPU output
    always @(posedge clk) begin
        if (stall_on) begin
            cpu_out_ready <= 1'($urandom % 2);
        end else begin
            cpu_out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        if (reset || (cpu_in_valid && cpu_in_ready)) begin
            seen_ids  <= '0;
            words_out <= 0;
        end else if (cpu_out_valid && cpu_out_ready) begin
            words_out <= words_out + 1;
            if (out_header == header_result && src_in_range) begin
                seen_ids[out_source - 1] <= 1'b1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) $fell(reset) |-> !cpu_out_valid)
        else report_failure("cpu_out_valid high right after reset");

    a_no_take_pending: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid |-> !(cpu_in_valid && cpu_in_ready))
        else report_failure("CPU word taken while an output was pending");

    a_out_allowed: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid |-> out_allowed)
        else report_failure("unexpected word on the CPU output");

    a_known_header: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid |-> (out_header == header_result || out_header == header_latency))
        else report_failure("CPU output word has an unknown header");

    a_quiet_single: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid && !report_mode |-> out_header == header_latency && words_out == 0)
        else report_failure("more than the latency report seen with results hidden");

    a_report_count: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid && report_mode && out_header == header_result |->
        words_out < num_children)
        else report_failure("too many result words reached the CPU");

    a_results_first: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid && out_header == header_latency |-> !report_mode || (&seen_ids))
        else report_failure("latency report came before every result");

    a_latency_value: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid && out_header == header_latency |->
        cpu_out_data[47] && cpu_out_data[15:0] == 16'(num_children - 1))
        else report_failure("latency report has wrong flag or latency");

    a_source_once: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid && out_header == header_result |->
        src_in_range && !seen_ids[out_source - 1])
        else report_failure("result source id out of range or repeated");

    a_boundary: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid && out_header == header_result && src_in_range |->
        cpu_out_data.res.boundary == exp_boundary[out_source - 1])
        else report_failure("result carries a wrong boundary");

    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid && !cpu_out_ready |=> cpu_out_valid && $stable(cpu_out_data))
        else report_failure("CPU output changed while stalled");

    initial begin
        logic [7:0] value;
        int         n;
        void'($urandom(32'hd19e_7d3f));
        reset        = 1'b1;
        cpu_in_data  = '0;
        cpu_in_valid = 1'b0;
        out_allowed  = 1'b0;
        report_mode  = 1'b0;
        stall_on     = 1'b0;
        for (int k = 0; k < num_children; k++) begin
            exp_boundary[k] = 8'h00;
        end
        repeat (16) @(posedge clk);
        reset    <= 1'b0;
        stall_on <= 1'b1;

        // clock reset, then a hidden wait that only reports latency
        send_word(build_command(dest_root, header_reset_clock, 8'h00, 8'h00, 1'b0, 1'b0));
        run_decode(1'b0);

        // results pass through, next command queued behind the report
        for (int round = 0; round < 3; round++) begin
            send_word(build_command(dest_root, header_decode_block, 8'h00,
                                    8'($urandom % 24), 1'b1, 1'b1));
            out_allowed <= 1'b1;
            report_mode <= 1'b1;
            fork
                await_report();
                send_word(build_command(dest_root, header_reset_clock, 8'h00, 8'h00,
                                        1'b0, 1'b0));
            join
        end

        // one child at a time gets a new boundary
        for (int k = 1; k <= num_children; k++) begin
            value = 8'($urandom % 255) + 8'd1;
            send_word(build_command(8'(k), header_set_boundaries, value, 8'h00, 1'b0, 1'b0));
            exp_boundary[k-1] <= value;
            run_decode(1'b1);
        end
        send_word(build_command(dest_root, header_initialize_decoding, 8'h00, 8'h00,
                                1'b0, 1'b0));
        for (int k = 0; k < num_children; k++) begin
            exp_boundary[k] <= 8'h00;
        end
        run_decode(1'b1);

        // unknown root header is swallowed
        send_word(build_command(dest_root, 8'h2a, 8'h00, 8'h00, 1'b0, 1'b0));

        // decode without wait, results stay parked in the children
        send_word(build_command(dest_root, header_decode_block, 8'h00, 8'($urandom % 24),
                                1'b0, 1'b0));
        n = 0;
        @(negedge clk);
        while (cpu_in_ready && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        stop_on_timeout(!cpu_in_ready, "the children never held their results");
        repeat (20) @(posedge clk);

        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog/child_node.sv
module child_node import ctrl_msg_pkg::*; #(
    parameter int child_id = 0
) (
    input  logic      clk,
    input  logic      reset,

    input  msg_word_u cmd_data,
    input  logic      cmd_valid,
    output logic      cmd_ready,

    output msg_word_u result_data,
    output logic      result_valid,
    input  logic      result_ready
);

    logic [15:0] timestamp;
    logic [15:0] remaining;
    logic [7:0]  boundary;
    logic        decoding;
    logic        cmd_fire;
    logic        done;

    // blocked while decoding or holding a result
    assign cmd_ready = !decoding && !result_valid;
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign done      = decoding && (remaining == '0);

    // free running, cleared by reset_clock
    always_ff @(posedge clk) begin
        if (reset) begin
            timestamp <= '0;
        end else if (cmd_fire && cmd_data.cmd.header == header_reset_clock) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoding     <= 1'b0;
            remaining    <= '0;
            boundary     <= '0;
            result_valid <= 1'b0;
        end else begin
            if (cmd_fire) begin
                case (cmd_data.cmd.header)
                    header_set_boundaries:      boundary <= cmd_data.cmd.boundary;
                    header_initialize_decoding: boundary <= '0;
                    header_decode_block: begin
                        // later children take longer
                        decoding  <= 1'b1;
                        remaining <= 16'(cmd_data.cmd.decode_cycles) + 16'(child_id);
                    end
                    default: ;
                endcase
            end
            if (done) begin
                decoding     <= 1'b0;
                result_valid <= 1'b1;
            end else if (decoding) begin
                remaining <= remaining - 1'b1;
            end
            if (result_valid && result_ready) begin
                result_valid <= 1'b0;
            end
        end
    end

    // result word latched at completion
    always_ff @(posedge clk) begin
        if (done) begin
            result_data.res <= '{
                dest:      dest_root,
                header:    header_result,
                source_id: 8'(child_id + 1),
                boundary:  boundary,
                timestamp: timestamp,
                spare:     16'h0000
            };
        end
    end

endmodule

// File: verilog/ctrl_msg_pkg.sv
package ctrl_msg_pkg;

    // header codes carried in bits 55:48
    localparam logic [7:0] header_initialize_decoding = 8'd1;
    localparam logic [7:0] header_set_boundaries      = 8'd2;
    localparam logic [7:0] header_decode_block        = 8'd3;
    localparam logic [7:0] header_reset_clock         = 8'd4;
    localparam logic [7:0] header_result              = 8'd5;
    localparam logic [7:0] header_latency             = 8'd6;

    // special destinations
    localparam logic [7:0] dest_root      = 8'h00;
    localparam logic [7:0] dest_broadcast = 8'hff;

    // root stages
    typedef enum logic [1:0] {
        stage_idle,
        stage_wait_results
    } stage_t;

    // command as sent from the CPU down the tree
    typedef struct packed {
        logic [7:0]  dest;
        logic [7:0]  header;
        logic [7:0]  boundary;
        logic [23:0] spare_hi;
        logic [7:0]  decode_cycles;
        logic [3:0]  spare_mid;
        logic        report_all;
        logic        wait_result;
        logic [1:0]  spare_lo;
    } cmd_view_t;

    // result or report travelling back up
    typedef struct packed {
        logic [7:0]  dest;
        logic [7:0]  header;
        logic [7:0]  source_id;
        logic [7:0]  boundary;
        logic [15:0] timestamp;
        logic [15:0] spare;
    } res_view_t;

    // one 64-bit control word, decoded by direction
    typedef union packed {
        cmd_view_t cmd;
        res_view_t res;
    } msg_word_u;

endpackage

// File: verilog/decoder_ctrl_top.sv
module decoder_ctrl_top import ctrl_msg_pkg::*; #(
    parameter int num_children = 4
) (
    input  logic      clk,
    input  logic      reset,

    input  msg_word_u cpu_in_data,
    input  logic      cpu_in_valid,
    output logic      cpu_in_ready,

    output msg_word_u cpu_out_data,
    output logic      cpu_out_valid,
    input  logic      cpu_out_ready
);

    msg_word_u               down_data;
    logic                    down_valid;
    logic                    down_ready;
    msg_word_u               up_data;
    logic                    up_valid;
    logic                    up_ready;
    logic                    router_busy;

    logic [num_children-1:0] child_valid;
    logic [num_children-1:0] child_ready;
    msg_word_u               result_data [num_children];
    logic [num_children-1:0] result_valid;
    logic [num_children-1:0] result_ready;

    root_controller #(
        .num_children(num_children)
    ) root_i (
        .clk          (clk),
        .reset        (reset),
        .cpu_in_data  (cpu_in_data),
        .cpu_in_valid (cpu_in_valid),
        .cpu_in_ready (cpu_in_ready),
        .cpu_out_data (cpu_out_data),
        .cpu_out_valid(cpu_out_valid),
        .cpu_out_ready(cpu_out_ready),
        .down_data    (down_data),
        .down_valid   (down_valid),
        .down_ready   (down_ready),
        .up_data      (up_data),
        .up_valid     (up_valid),
        .up_ready     (up_ready),
        .router_busy  (router_busy)
    );

    fpga_link_router #(
        .num_children(num_children)
    ) router_i (
        .clk         (clk),
        .reset       (reset),
        .down_data   (down_data),
        .down_valid  (down_valid),
        .down_ready  (down_ready),
        .child_valid (child_valid),
        .child_ready (child_ready),
        .result_data (result_data),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .up_data     (up_data),
        .up_valid    (up_valid),
        .up_ready    (up_ready),
        .router_busy (router_busy)
    );

    // stand-ins for the remote decoder boards
    for (genvar k = 0; k < num_children; k++) begin : g_child
        child_node #(
            .child_id(k)
        ) child_i (
            .clk         (clk),
            .reset       (reset),
            .cmd_data    (down_data),
            .cmd_valid   (child_valid[k]),
            .cmd_ready   (child_ready[k]),
            .result_data (result_data[k]),
            .result_valid(result_valid[k]),
            .result_ready(result_ready[k])
        );
    end

endmodule

// File: verilog/fpga_link_router.sv
module fpga_link_router import ctrl_msg_pkg::*; #(
    parameter int num_children = 4
) (
    input  logic                    clk,
    input  logic                    reset,

    input  msg_word_u               down_data,
    input  logic                    down_valid,
    output logic                    down_ready,

    output logic [num_children-1:0] child_valid,
    input  logic [num_children-1:0] child_ready,

    input  msg_word_u               result_data [num_children],
    input  logic [num_children-1:0] result_valid,
    output logic [num_children-1:0] result_ready,

    output msg_word_u               up_data,
    output logic                    up_valid,
    input  logic                    up_ready,

    output logic                    router_busy
);

    localparam int idx_w = (num_children > 1) ? $clog2(num_children) : 1;

    logic [idx_w-1:0] last_grant;
    logic [idx_w-1:0] sel_idx;
    logic [idx_w-1:0] pick;
    logic [idx_w-1:0] lock_idx;
    logic             lock_q;
    logic             found;

    // fan-out on dest
    always_comb begin
        down_ready  = 1'b1;
        child_valid = '0;
        if (down_data.cmd.dest == dest_broadcast) begin
            // all children must take it together
            down_ready  = &child_ready;
            child_valid = {num_children{down_valid && (&child_ready)}};
        end else begin
            for (int k = 0; k < num_children; k++) begin
                if (down_data.cmd.dest == 8'(k + 1)) begin
                    down_ready     = child_ready[k];
                    child_valid[k] = down_valid;
                end
            end
        end
    end

    // round-robin search starting after last grant
    always_comb begin
        int j;
        found   = 1'b0;
        sel_idx = last_grant;
        for (int i = 1; i <= num_children; i++) begin
            j = (int'(last_grant) + i) % num_children;
            if (!found && result_valid[j]) begin
                found   = 1'b1;
                sel_idx = idx_w'(j);
            end
        end
    end

    // a stalled result keeps its slot so data stays stable
    assign pick     = lock_q ? lock_idx : sel_idx;
    assign up_data  = result_data[pick];
    assign up_valid = result_valid[pick];

    always_comb begin
        result_ready       = '0;
        result_ready[pick] = up_ready && result_valid[pick];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_grant <= idx_w'(num_children - 1);
            lock_q     <= 1'b0;
        end else if (up_valid && up_ready) begin
            last_grant <= pick;
            lock_q     <= 1'b0;
        end else if (up_valid) begin
            lock_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        lock_idx <= pick;
    end

    assign router_busy = |result_valid;

    a_grant_hold: assert property (@(posedge clk) disable iff (reset)
        up_valid && !up_ready |=> up_valid && $stable(up_data));

endmodule

// File: verilog/root_controller.sv
module root_controller import ctrl_msg_pkg::*; #(
    parameter int num_children = 4
) (
    input  logic      clk,
    input  logic      reset,

    input  msg_word_u cpu_in_data,
    input  logic      cpu_in_valid,
    output logic      cpu_in_ready,

    output msg_word_u cpu_out_data,
    output logic      cpu_out_valid,
    input  logic      cpu_out_ready,

    output msg_word_u down_data,
    output logic      down_valid,
    input  logic      down_ready,

    input  msg_word_u up_data,
    input  logic      up_valid,
    output logic      up_ready,

    input  logic      router_busy
);

    localparam int count_w = $clog2(num_children + 1);

    stage_t             stage;
    logic               report_all;
    logic [count_w-1:0] result_count;
    logic [15:0]        first_ts;
    logic [15:0]        latency_q;
    logic               busy_q;

    logic               forward;
    logic               cpu_in_fire;
    logic               up_fire;
    logic               all_collected;
    logic [15:0]        first_sel;
    logic [15:0]        span;

    assign cpu_in_fire   = cpu_in_valid && cpu_in_ready;
    assign up_fire       = up_valid && up_ready;
    assign all_collected = (result_count == count_w'(num_children));

    // one result may be both first and last with a single child
    assign first_sel = (result_count == '0) ? up_data.res.timestamp : first_ts;
    assign span      = up_data.res.timestamp - first_sel;

    // router busy goes through one register before use
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= router_busy;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage        <= stage_idle;
            report_all   <= 1'b0;
            result_count <= '0;
        end else begin
            case (stage)
                stage_idle: begin
                    result_count <= '0;
                    if (cpu_in_fire && cpu_in_data.cmd.dest == dest_root &&
                        cpu_in_data.cmd.header == header_decode_block) begin
                        report_all <= cpu_in_data.cmd.report_all;
                        if (cpu_in_data.cmd.wait_result) begin
                            stage <= stage_wait_results;
                        end
                    end
                end
                stage_wait_results: begin
                    if (up_fire) begin
                        result_count <= result_count + 1'b1;
                    end else if (all_collected && cpu_out_ready) begin
                        // report taken by the CPU
                        result_count <= '0;
                        stage        <= stage_idle;
                    end
                end
                default: begin
                    stage <= stage_idle;
                end
            endcase
        end
    end

    // timestamps of first and last result
    always_ff @(posedge clk) begin
        if (stage == stage_wait_results && up_fire) begin
            if (result_count == '0) begin
                first_ts <= up_data.res.timestamp;
            end
            if (result_count == count_w'(num_children - 1)) begin
                latency_q <= span;
            end
        end
    end

    // cpu to children, root commands become broadcasts
    always_comb begin
        down_data = cpu_in_data;
        forward   = 1'b1;
        if (cpu_in_data.cmd.dest == dest_root) begin
            case (cpu_in_data.cmd.header)
                header_initialize_decoding,
                header_decode_block,
                header_reset_clock: begin
                    down_data.cmd.dest = dest_broadcast;
                end
                header_set_boundaries: begin
                    forward = 1'b1;
                end
                default: begin
                    // unknown root command is swallowed
                    forward = 1'b0;
                end
            endcase
        end
    end

    assign cpu_in_ready = (stage == stage_idle) && down_ready && !busy_q;
    assign down_valid   = cpu_in_fire && forward;

    // children to cpu
    always_comb begin
        cpu_out_data  = up_data;
        cpu_out_valid = 1'b0;
        up_ready      = 1'b0;
        if (stage == stage_wait_results) begin
            if (all_collected) begin
                cpu_out_data.res = '{
                    dest:      dest_root,
                    header:    header_latency,
                    source_id: 8'h80,
                    boundary:  8'h00,
                    timestamp: 16'h0000,
                    spare:     latency_q
                };
                cpu_out_valid = 1'b1;
            end else if (report_all) begin
                cpu_out_valid = up_valid;
                up_ready      = cpu_out_ready;
            end else begin
                // drain silently
                up_ready = 1'b1;
            end
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        cpu_out_valid && !cpu_out_ready |=> cpu_out_valid);

    a_count_limit: assert property (@(posedge clk) disable iff (reset)
        result_count <= count_w'(num_children));

endmodule
